// ==== hw/uart_pkg.sv ====
package uart_pkg;

    // Sample ticks per bit period
    localparam int OVERSAMPLE = 16;

    // Defaults taken by the top level parameters
    localparam int DEF_DBIT       = 8;         // Data bits per frame
    localparam int DEF_SB_TICK    = 16;        // One stop bit
    localparam int DEF_DVSR       = 27;        // Clocks per sample tick
    localparam int DEF_FIFO_DEPTH = 4;         // Echo queue entries

    // Receiver FSM
    typedef enum logic [1:0] {
        rx_st_idle  = 2'b00,                   // Waiting for falling edge
        rx_st_start = 2'b01,                   // Validating start bit
        rx_st_data  = 2'b10,                   // Sampling data bits
        rx_st_stop  = 2'b11                    // Checking stop bit
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        tx_st_idle  = 2'b00,                   // Line high, waiting for strobe
        tx_st_start = 2'b01,                   // Driving start bit
        tx_st_data  = 2'b10,                   // Shifting data bits out
        tx_st_stop  = 2'b11                    // Holding stop level
    } tx_state_t;

endpackage

// ==== hw/baud_gen.sv ====
`timescale 1ns/100ps

module baud_gen
#(
    parameter int DVSR = 27                    // Clocks per sample tick
)
(
    input  logic i_clk,                        // System clock
    input  logic i_reset,                      // Async reset, active high
    output logic o_s_tick                      // One-cycle tick at 16x baud
);

    // Counter width from the divisor, at least one bit
    localparam int CW = (DVSR > 1) ? $clog2(DVSR) : 1;
    localparam logic [CW-1:0] RELOAD = CW'(DVSR - 1);

    logic [CW-1:0] cnt_reg;                    // Down counter

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            cnt_reg <= RELOAD;                 // First tick DVSR clocks after reset
        end
        else if (cnt_reg == '0)
        begin
            cnt_reg <= RELOAD;                 // Wrap
        end
        else
        begin
            cnt_reg <= cnt_reg - 1'b1;         // Count down
        end
    end

    // Tick while counter sits at zero
    assign o_s_tick = (cnt_reg == '0);

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx
#(
    parameter int DBIT    = 8,                 // Data bits per frame
    parameter int SB_TICK = 16                 // Ticks for stop bit
)
(
    input  logic            i_clk,             // System clock
    input  logic            i_reset,           // Async reset, active high
    input  logic            i_s_tick,          // Sample tick from baud_gen
    input  logic            i_rx,              // Serial line, async
    output logic [DBIT-1:0] o_data,            // Received byte
    output logic            o_rx_done_tick,    // Good frame pulse
    output logic            o_frame_err_tick   // Stop bit low pulse
);

    // Tick counter must hold both OVERSAMPLE-1 and SB_TICK-1
    localparam int TW = ($clog2(SB_TICK) > 4) ? $clog2(SB_TICK) : 4;
    localparam int NW = (DBIT > 1) ? $clog2(DBIT) : 1;
    localparam logic [TW-1:0] HALF_LAST = TW'(uart_pkg::OVERSAMPLE / 2 - 1);
    localparam logic [TW-1:0] BIT_LAST  = TW'(uart_pkg::OVERSAMPLE - 1);
    localparam logic [TW-1:0] STOP_LAST = TW'(SB_TICK - 1);
    localparam logic [NW-1:0] DBIT_LAST = NW'(DBIT - 1);

    uart_pkg::rx_state_t state_reg, state_next; // FSM state
    logic [TW-1:0]       s_reg, s_next;        // Sample ticks within bit
    logic [NW-1:0]       n_reg, n_next;        // Data bits taken
    logic [DBIT-1:0]     b_reg, b_next;        // Shift register, LSB first
    logic                rx_meta;              // Sync stage 1
    logic                rx_sync;              // Sync stage 2
    logic                rx_prev;              // Delayed for edge detect
    logic                fall;                 // Falling edge on line

    // Two-flop synchronizer plus edge history, idle level is high
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Edge only, so a line held low after a bad stop bit does not restart
    assign fall = rx_prev & ~rx_sync;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state_reg <= uart_pkg::rx_st_idle;
            s_reg     <= '0;
            n_reg     <= '0;
        end
        else
        begin
            state_reg <= state_next;
            s_reg     <= s_next;
            n_reg     <= n_next;
        end
    end

    // Data shift register
    always_ff @(posedge i_clk)
    begin
        b_reg <= b_next;
    end

    always_comb
    begin
        state_next       = state_reg;
        s_next           = s_reg;
        n_next           = n_reg;
        b_next           = b_reg;
        o_rx_done_tick   = 1'b0;
        o_frame_err_tick = 1'b0;
        case (state_reg)
            uart_pkg::rx_st_idle:
            begin
                if (fall)
                begin
                    state_next = uart_pkg::rx_st_start;
                    s_next     = '0;           // Count toward start bit centre
                end
            end
            uart_pkg::rx_st_start:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == HALF_LAST)    // Centre of start bit
                    begin
                        if (!rx_sync)
                        begin
                            state_next = uart_pkg::rx_st_data; // Start bit confirmed
                            s_next     = '0;
                            n_next     = '0;
                        end
                        else
                        begin
                            state_next = uart_pkg::rx_st_idle; // Glitch, drop it
                        end
                    end
                    else
                    begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            uart_pkg::rx_st_data:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == BIT_LAST)     // Next bit centre
                    begin
                        s_next = '0;
                        b_next = {rx_sync, b_reg[DBIT-1:1]}; // LSB arrives first
                        if (n_reg == DBIT_LAST)
                            state_next = uart_pkg::rx_st_stop;
                        else
                            n_next = n_reg + 1'b1;
                    end
                    else
                    begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            uart_pkg::rx_st_stop:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == STOP_LAST)
                    begin
                        state_next = uart_pkg::rx_st_idle;
                        if (rx_sync)
                            o_rx_done_tick = 1'b1;   // Valid frame
                        else
                            o_frame_err_tick = 1'b1; // Stop bit low, byte dropped
                    end
                    else
                    begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            default: state_next = uart_pkg::rx_st_idle;
        endcase
    end

    assign o_data = b_reg;                     // Stable through done pulse

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx
#(
    parameter int DBIT    = 8,                 // Data bits per frame
    parameter int SB_TICK = 16                 // Ticks for stop bit
)
(
    input  logic            i_clk,             // System clock
    input  logic            i_reset,           // Async reset, active high
    input  logic            i_tx_start,        // Launch strobe
    input  logic            i_s_tick,          // Sample tick from baud_gen
    input  logic [DBIT-1:0] i_data,            // Byte, latched on strobe
    output logic            o_tx_done_tick,    // End of stop level
    output logic            o_tx               // Serial line
);

    localparam int NW = (DBIT > 1) ? $clog2(DBIT) : 1;
    localparam logic [3:0]    BIT_LAST  = 4'(uart_pkg::OVERSAMPLE - 1);
    localparam logic [3:0]    STOP_LAST = 4'(SB_TICK - 1);
    localparam logic [NW-1:0] DBIT_LAST = NW'(DBIT - 1);

    uart_pkg::tx_state_t state_reg, state_next; // FSM state
    logic [3:0]          s_reg, s_next;        // Ticks within bit
    logic [NW-1:0]       n_reg, n_next;        // Data bits sent
    logic [DBIT-1:0]     b_reg, b_next;        // Shifts right, LSB out
    logic                tx_reg, tx_next;      // Registered line level

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state_reg <= uart_pkg::tx_st_idle;
            s_reg     <= '0;
            n_reg     <= '0;
            tx_reg    <= 1'b1;                 // Line idles high
        end
        else
        begin
            state_reg <= state_next;
            s_reg     <= s_next;
            n_reg     <= n_next;
            tx_reg    <= tx_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        b_reg <= b_next;
    end

    // Level changes are set on the transition so every bit spans whole tick periods
    always_comb
    begin
        state_next     = state_reg;
        s_next         = s_reg;
        n_next         = n_reg;
        b_next         = b_reg;
        tx_next        = tx_reg;
        o_tx_done_tick = 1'b0;
        case (state_reg)
            uart_pkg::tx_st_idle:
            begin
                tx_next = 1'b1;
                if (i_tx_start)
                begin
                    state_next = uart_pkg::tx_st_start;
                    s_next     = '0;
                    b_next     = i_data;       // Capture byte
                    tx_next    = 1'b0;         // Start bit on next clock
                end
            end
            uart_pkg::tx_st_start:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == BIT_LAST)
                    begin
                        state_next = uart_pkg::tx_st_data;
                        s_next     = '0;
                        n_next     = '0;
                        tx_next    = b_reg[0]; // First data bit
                    end
                    else
                    begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            uart_pkg::tx_st_data:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == BIT_LAST)
                    begin
                        s_next  = '0;
                        b_next  = b_reg >> 1;
                        tx_next = b_next[0];   // Following bit
                        if (n_reg == DBIT_LAST)
                        begin
                            state_next = uart_pkg::tx_st_stop;
                            tx_next    = 1'b1; // Stop level
                        end
                        else
                        begin
                            n_next = n_reg + 1'b1;
                        end
                    end
                    else
                    begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            uart_pkg::tx_st_stop:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == STOP_LAST)
                    begin
                        state_next     = uart_pkg::tx_st_idle;
                        o_tx_done_tick = 1'b1;
                    end
                    else
                    begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            default: state_next = uart_pkg::tx_st_idle;
        endcase
    end

    assign o_tx = tx_reg;                      // Straight from flop, no glitches

endmodule

// ==== hw/echo_fifo.sv ====
`timescale 1ns/100ps

module echo_fifo
#(
    parameter int DBIT       = 8,              // Byte width
    parameter int FIFO_DEPTH = 4               // Entries, power of two
)
(
    input  logic            i_clk,             // System clock
    input  logic            i_reset,           // Async reset, active high
    input  logic            i_rx_done_tick,    // Byte from receiver
    input  logic [DBIT-1:0] i_rx_data,         // Received byte
    input  logic            i_tx_done_tick,    // Transmitter finished frame
    output logic            o_tx_start,        // Launch strobe
    output logic [DBIT-1:0] o_tx_data,         // Head entry
    output logic            o_overrun,         // Byte dropped pulse
    output logic [7:0]      o_overrun_count    // Saturating drop count
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] DEPTH = (AW + 1)'(FIFO_DEPTH);

    logic [DBIT-1:0] mem [FIFO_DEPTH];         // Circular buffer
    logic [AW:0]     wr_ptr, rd_ptr;           // Extra bit tells full from empty
    logic [AW:0]     fill;                     // Entries held
    logic            empty, full;
    logic            busy_reg;                 // Frame in transmitter
    logic            push, pop, drop;
    logic            overrun_reg;
    logic [7:0]      ovf_cnt;

    assign fill  = wr_ptr - rd_ptr;
    assign empty = (fill == '0);
    assign full  = (fill == DEPTH);
    assign pop   = !empty && !busy_reg;        // Launch one frame at a time
    assign push  = i_rx_done_tick && (!full || pop); // Slot freed by same-cycle pop
    assign drop  = i_rx_done_tick && !push;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            busy_reg    <= 1'b0;
            overrun_reg <= 1'b0;
            ovf_cnt     <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;   // Head leaves with the strobe
            if (pop)
                busy_reg <= 1'b1;
            else if (i_tx_done_tick)
                busy_reg <= 1'b0;
            overrun_reg <= drop;
            if (drop && ovf_cnt != 8'hff)
                ovf_cnt <= ovf_cnt + 1'b1; // Stick at 255
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (push)
            mem[wr_ptr[AW-1:0]] <= i_rx_data;
    end

    assign o_tx_start      = pop;
    assign o_tx_data       = mem[rd_ptr[AW-1:0]]; // Transmitter latches on strobe
    assign o_overrun       = overrun_reg;
    assign o_overrun_count = ovf_cnt;

endmodule

// ==== hw/uart_echo_top.sv ====
`timescale 1ns/100ps

module uart_echo_top
#(
    parameter int DBIT       = uart_pkg::DEF_DBIT,       // Data bits per frame
    parameter int SB_TICK    = uart_pkg::DEF_SB_TICK,    // Stop length in ticks
    parameter int DVSR       = uart_pkg::DEF_DVSR,       // Clocks per tick
    parameter int FIFO_DEPTH = uart_pkg::DEF_FIFO_DEPTH  // Echo queue size
)
(
    input  logic            i_clk,             // System clock
    input  logic            i_reset,           // Async reset, active high
    input  logic            i_rx,              // Serial in
    output logic            o_tx,              // Serial out
    output logic            o_rx_valid,        // Byte received
    output logic            o_frame_err,       // Bad stop bit
    output logic            o_overrun,         // Queue full, byte dropped
    output logic [DBIT-1:0] o_rx_data,         // Received byte
    output logic [7:0]      o_overrun_count    // Drops so far
);

    logic            s_tick;                   // Shared sample tick
    logic [DBIT-1:0] rx_data;
    logic            rx_done_tick;
    logic            frame_err_tick;
    logic            tx_start;
    logic [DBIT-1:0] tx_data;
    logic            tx_done_tick;

    baud_gen #(.DVSR(DVSR)) u_baud_gen (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .o_s_tick (s_tick)
    );

    uart_rx #(.DBIT(DBIT), .SB_TICK(SB_TICK)) u_uart_rx (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_s_tick         (s_tick),
        .i_rx             (i_rx),
        .o_data           (rx_data),
        .o_rx_done_tick   (rx_done_tick),
        .o_frame_err_tick (frame_err_tick)
    );

    echo_fifo #(.DBIT(DBIT), .FIFO_DEPTH(FIFO_DEPTH)) u_echo_fifo (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_rx_done_tick  (rx_done_tick),
        .i_rx_data       (rx_data),
        .i_tx_done_tick  (tx_done_tick),
        .o_tx_start      (tx_start),
        .o_tx_data       (tx_data),
        .o_overrun       (o_overrun),
        .o_overrun_count (o_overrun_count)
    );

    uart_tx #(.DBIT(DBIT), .SB_TICK(SB_TICK)) u_uart_tx (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_tx_start     (tx_start),
        .i_s_tick       (s_tick),
        .i_data         (tx_data),
        .o_tx_done_tick (tx_done_tick),
        .o_tx           (o_tx)
    );

    // Receiver results mirrored outside
    assign o_rx_valid  = rx_done_tick;
    assign o_rx_data   = rx_data;
    assign o_frame_err = frame_err_tick;

endmodule

// ==== verification/uart_echo_sva.sv ====
`timescale 1ns/100ps

module uart_echo_sva
#(
    parameter int FIFO_DEPTH = 4               // Queue entries
)
(
    input logic                        i_clk,
    input logic                        i_reset,
    input uart_pkg::tx_state_t         i_tx_state, // Transmitter FSM
    input logic                        i_tx_line,  // Registered serial out
    input logic                        i_tx_start, // Queue launch strobe
    input logic [$clog2(FIFO_DEPTH):0] i_wr_ptr,
    input logic [$clog2(FIFO_DEPTH):0] i_rd_ptr
);

    logic [$clog2(FIFO_DEPTH):0] fill;         // Entries held modulo pointer width

    assign fill = i_wr_ptr - i_rd_ptr;

    a_idle_line_high: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_tx_state == uart_pkg::tx_st_idle) |-> i_tx_line)
        else $error("o_tx low while transmitter idle");

    // Transmitter away from idle means a frame is still in flight
    a_no_start_when_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_tx_state != uart_pkg::tx_st_idle) |-> !i_tx_start)
        else $error("tx_start raised while a frame is in flight");

    a_fill_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
        fill <= FIFO_DEPTH)
        else $error("queue pointers differ by more than the depth");

endmodule

bind uart_echo_top uart_echo_sva #(.FIFO_DEPTH(FIFO_DEPTH)) u_echo_sva (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_tx_state (u_uart_tx.state_reg),
    .i_tx_line  (u_uart_tx.o_tx),
    .i_tx_start (u_echo_fifo.o_tx_start),
    .i_wr_ptr   (u_echo_fifo.wr_ptr),
    .i_rd_ptr   (u_echo_fifo.rd_ptr)
);

// ==== verification/uart_echo_tb.sv ====
`timescale 1ns/100ps

module uart_echo_tb;

    localparam int DBIT       = 8;
    localparam int SB_TICK    = 16;
    localparam int DVSR       = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int BIT_CLKS   = uart_pkg::OVERSAMPLE * DVSR; // Clocks per serial bit
    localparam int FRAME_CLKS = (DBIT + 2) * BIT_CLKS;       // Start, data, one stop
    localparam int WAIT_LIMIT = 8 * FRAME_CLKS;              // Timeout per wait loop

    logic            i_clk;
    logic            i_reset;
    logic            i_rx;
    logic            o_tx;
    logic            o_rx_valid;
    logic            o_frame_err;
    logic            o_overrun;
    logic [DBIT-1:0] o_rx_data;
    logic [7:0]      o_overrun_count;

    logic [DBIT-1:0] exp_rx[$];                // Good frames sent
    logic [DBIT-1:0] got_rx[$];                // Bytes seen on o_rx_data
    logic [DBIT-1:0] exp_echo[$];              // Model echo order
    logic [DBIT-1:0] got_echo[$];              // Bytes decoded from o_tx
    int errors;
    int checks;
    int model_count;                           // Received, not yet echoed
    int model_drops;                           // Bytes the model expects lost
    int model_bad;                             // Frames sent with low stop bit
    int frame_errs;
    int overrun_pulses;

    uart_echo_top #(
        .DBIT       (DBIT),
        .SB_TICK    (SB_TICK),
        .DVSR       (DVSR),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_rx            (i_rx),
        .o_tx            (o_tx),
        .o_rx_valid      (o_rx_valid),
        .o_frame_err     (o_frame_err),
        .o_overrun       (o_overrun),
        .o_rx_data       (o_rx_data),
        .o_overrun_count (o_overrun_count)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;             // 10 ns period
    end

    // Receive side pulses, sampled mid-cycle
    always @(negedge i_clk)
    begin
        if (!i_reset)
        begin
            if (o_rx_valid === 1'b1)
                got_rx.push_back(o_rx_data);
            if (o_frame_err === 1'b1)
                frame_errs++;
            if (o_overrun === 1'b1)
                overrun_pulses++;
        end
    end

    // Serial decoder on o_tx, samples at bit centres
    initial
    begin : tx_monitor
        logic [DBIT-1:0] bits;
        forever
        begin
            @(negedge i_clk);
            if (!i_reset && o_tx === 1'b0)
            begin
                repeat (BIT_CLKS / 2) @(negedge i_clk); // Centre of start bit
                if (o_tx !== 1'b0)
                begin
                    errors++;
                    $display("ERROR: start bit on o_tx ended early at %0t", $time);
                end
                else
                begin
                    for (int i = 0; i < DBIT; i++)
                    begin
                        repeat (BIT_CLKS) @(negedge i_clk);
                        bits[i] = o_tx;        // LSB first
                    end
                    repeat (BIT_CLKS) @(negedge i_clk);
                    if (o_tx !== 1'b1)
                    begin
                        errors++;
                        $display("ERROR: stop bit on o_tx was low at %0t", $time);
                    end
                    got_echo.push_back(bits);
                    model_count--;             // Frame fully echoed
                end
            end
        end
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // Queue admits a byte only while the model count is below depth
    task automatic accept_into_model(input logic [DBIT-1:0] data);
        if (model_count < FIFO_DEPTH)
        begin
            exp_echo.push_back(data);
            model_count++;
        end
        else
        begin
            model_drops++;
        end
    endtask

    task automatic drive_bit(input logic level);
        i_rx <= level;
        repeat (BIT_CLKS) @(posedge i_clk);    // Hold one bit period
    endtask

    // Called on a rising edge, returns on the edge after the stop bit
    task automatic send_frame(input logic [DBIT-1:0] data, input logic bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < DBIT; i++)
            drive_bit(data[i]);
        drive_bit(!bad_stop);
        if (bad_stop)
        begin
            i_rx <= 1'b1;                      // Back to idle
            model_bad++;
        end
        else
        begin
            exp_rx.push_back(data);
            accept_into_model(data);
        end
    endtask

    task automatic settle_and_compare(input string name);
        int n;
        n = 0;
        while ((got_echo.size() < exp_echo.size() || got_rx.size() < exp_rx.size())
               && n < WAIT_LIMIT)
        begin
            @(posedge i_clk);
            n++;
        end
        if (got_echo.size() < exp_echo.size() || got_rx.size() < exp_rx.size())
        begin
            errors++;
            $display("ERROR: %s timed out waiting for frames after %0d cycles", name, n);
        end
        repeat (2 * FRAME_CLKS) @(posedge i_clk); // Quiet line catches extra frames
        @(negedge i_clk);
        check_equal({name, "_rx_count"}, exp_rx.size(), got_rx.size());
        for (int i = 0; i < exp_rx.size() && i < got_rx.size(); i++)
            check_equal($sformatf("%s_rx_byte%0d", name, i), exp_rx[i], got_rx[i]);
        check_equal({name, "_echo_count"}, exp_echo.size(), got_echo.size());
        for (int i = 0; i < exp_echo.size() && i < got_echo.size(); i++)
            check_equal($sformatf("%s_echo_byte%0d", name, i), exp_echo[i], got_echo[i]);
        check_equal({name, "_frame_errs"}, model_bad, frame_errs);
        check_equal({name, "_overrun_count"}, model_drops, o_overrun_count);
        check_equal({name, "_overrun_pulses"}, model_drops, overrun_pulses);
        exp_rx.delete();
        got_rx.delete();
        exp_echo.delete();
        got_echo.delete();
        @(posedge i_clk);                      // Realign for the driver
    endtask

    initial
    begin
        logic [DBIT-1:0] b;
        void'($urandom(32'h53d6));
        i_reset = 1'b1;
        i_rx    = 1'b1;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (200)                           // Quiet outputs after reset
        begin
            @(negedge i_clk);
            check_equal("reset_idle_tx", 1, o_tx);
            check_equal("reset_idle_pulses", 0, {o_rx_valid, o_frame_err, o_overrun});
        end
        check_equal("reset_overrun_count", 0, o_overrun_count);
        @(posedge i_clk);
        for (int k = 0; k < 20; k++)           // Spaced bytes, one at a time
        begin
            b = DBIT'($urandom);
            send_frame(b, 1'b0);
            settle_and_compare("spaced_bytes");
        end
        for (int k = 0; k < 6; k++)            // Burst with no idle between frames
        begin
            b = DBIT'($urandom);
            send_frame(b, 1'b0);
        end
        settle_and_compare("back_to_back");
        b = DBIT'($urandom);
        send_frame(b, 1'b1);                   // Stop bit forced low
        settle_and_compare("bad_stop_bit");
        i_rx <= 1'b0;                          // Three tick glitch on idle line
        repeat (3 * DVSR) @(posedge i_clk);
        i_rx <= 1'b1;
        settle_and_compare("start_glitch");
        $display("checks %0d errors %0d drops %0d", checks, errors, model_drops);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== files.f ====
hw/uart_pkg.sv
hw/baud_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/echo_fifo.sv
hw/uart_echo_top.sv
verification/uart_echo_sva.sv
verification/uart_echo_tb.sv
